// ==== niu32.f ====
+incdir+hdl
hdl/niu32IsaPkg.sv
hdl/niu32CorePkg.sv
hdl/programLoader.sv
hdl/aluUnit.sv
hdl/controlSequencer.sv
hdl/datapath.sv
hdl/outputPort.sv
hdl/niu32Top.sv
test/niu32Tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the niu32 testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module niu32Tb -f niu32.f -o niu32Sim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/niu32Sim
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "Simulation failed with status $simStatus"
    exit $simStatus
fi

echo "Simulation finished"
exit 0

// ==== test/niu32Tb.sv ====
`timescale 1ns/1ns
`include "niu32_cfg.svh"

module niu32Tb import niu32IsaPkg::*, niu32CorePkg::*; ();

    localparam int   ClkHalf     = 20;
    localparam int   ResetCycles = 16;
    localparam int   LoadCycles  = 6;   // Per word with the handshake
    localparam int   StepCycles  = 8;   // Taken branch is the longest
    localparam int   QuietCycles = 20;
    localparam wordT HaltWord    = 32'hF800_0000;  // Primary opcode 11111 is undefined
    localparam immT  OutImm      = immT'(`NIU_ADDR_OUT);  // Sign-extends back to the address
    localparam immT  LedImm      = immT'(`NIU_ADDR_LEDR);
    localparam immT  SwitchImm   = immT'(`NIU_ADDR_SWITCH);

    logic                     clk;
    logic                     reset;
    logic                     loadReq;
    loadWordT                 loadWord;
    logic                     loadAck;
    logic [`NIU_LED_BITS-1:0] switches;
    logic                     outAck;
    logic                     outReq;
    wordT                     outData;
    logic [`NIU_LED_BITS-1:0] ledr;
    logic                     halted;

    wordT prog [$];
    wordT expected [$];
    int   extraSteps;   // Instructions executed beyond the program length
    int   maxAckDelay;
    int   cycleCount = 0;
    int   cycleLimit = ResetCycles;
    wordT lcgState = 32'd95585;

    niu32Top uut (
        .clk, .reset, .loadReq, .loadWord, .loadAck, .switches,
        .outAck, .outReq, .outData, .ledr, .halted
    );

    always #ClkHalf clk = ~clk;

    // Cycle limit grows with every program run
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    function automatic wordT nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic wordT sext(immT imm);
        return {{(`NIU_WORD_BITS - $bits(immT)){imm[16]}}, imm};
    endfunction

    function automatic wordT rOp(aluFuncT f, int x, int y, int z);
        return {opAlui, regIdxT'(x), regIdxT'(y), regIdxT'(z), 7'd0, f};
    endfunction

    function automatic wordT iOp(opcodeT op, int x, int y, immT imm);
        return {op, regIdxT'(x), regIdxT'(y), imm};
    endfunction

    // Reference results from the instruction rules
    function automatic wordT expectAlu(aluFuncT f, wordT a, wordT b);
        case (f)
            aluSub:  return a - b;
            aluAdd:  return a + b;
            aluMlt:  return a * b;
            aluNot:  return ~a;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSul:  return a << b[4:0];
            aluSur:  return a >> b[4:0];
            aluSsr:  return wordT'($signed(a) >>> b[4:0]);
            aluEq:   return {31'd0, a == b};
            aluNeq:  return {31'd0, a != b};
            aluLt:   return {31'd0, $signed(a) < $signed(b)};
            aluLeq:  return {31'd0, $signed(a) <= $signed(b)};
            default: return '0;
        endcase
    endfunction

    function automatic logic branchTaken(opcodeT op, wordT x, wordT y);
        case (op)
            opBeq:   return x == y;
            opBne:   return x != y;
            opBlt:   return $signed(x) < $signed(y);
            default: return $signed(x) <= $signed(y);
        endcase
    endfunction

    function automatic void emit(wordT w);
        prog.push_back(w);
    endfunction

    function automatic void storeOut(int r);
        emit(iOp(opSw, 0, r, OutImm));
    endfunction

    // Full 32-bit constant in three steps
    function automatic void loadConst(int r, wordT v);
        emit(iOp(opOri, 0, r, {1'b0, v[31:16]}));
        emit(iOp(opSuli, r, r, 17'd16));
        emit(iOp(opOri, r, r, {1'b0, v[15:0]}));
    endfunction

    function automatic void newProgram(int ackDelay, int steps);
        prog.delete();
        expected.delete();
        maxAckDelay = ackDelay;
        extraSteps  = steps;
    endfunction

    task automatic checkValue(input string testName, input wordT expectedVal,
                              input wordT actualVal);
        if (actualVal !== expectedVal) begin
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expectedVal,
                     actualVal);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        checkValue("reset halted", '0, wordT'(halted));
        checkValue("reset outReq", '0, wordT'(outReq));
        checkValue("reset loadAck", '0, wordT'(loadAck));
        checkValue("reset ledr", '0, wordT'(ledr));
        reset = 1'b0;
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            loadWord.addr = imemAddrT'(i);
            loadWord.data = prog[i];
            loadWord.last = (i == prog.size() - 1);
            loadReq = 1'b1;
            do @(negedge clk); while (!loadAck);
            loadReq = 1'b0;
            do @(negedge clk); while (loadAck);  // Return to zero
        end
    endtask

    task automatic receiveWords(input string name);
        int k;
        int delay;
        for (k = 0; k < expected.size(); k++) begin
            while (!outReq) @(negedge clk);
            checkValue({name, " halted before output"}, '0, wordT'(halted));
            checkValue(name, expected[k], outData);
            delay = int'(nextRandom() >> 16) % (maxAckDelay + 1);
            repeat (delay) @(negedge clk);
            outAck = 1'b1;
            while (outReq) @(negedge clk);
            outAck = 1'b0;
        end
    endtask

    task automatic waitHalt(input string name);
        int i;
        while (!halted) begin
            checkValue({name, " extra output"}, '0, wordT'(outReq));
            @(negedge clk);
        end
        for (i = 0; i < QuietCycles; i++) begin
            checkValue({name, " output after halt"}, '0, wordT'(outReq));
            @(negedge clk);
        end
    endtask

    task automatic runProgram(input string name);
        emit(HaltWord);
        cycleLimit += 2 * ResetCycles + prog.size() * LoadCycles
                    + (prog.size() + extraSteps) * StepCycles
                    + expected.size() * (maxAckDelay + StepCycles) + QuietCycles;
        applyReset();
        loadProgram();
        receiveWords(name);
        waitHalt(name);
    endtask

    task automatic aluTest();
        aluFuncT regFuncs [14];
        opcodeT  immOps [8];
        aluFuncT immFuncs [8];
        wordT    a;
        wordT    b;
        immT     imm;
        int      i;
        regFuncs = '{aluSub, aluAdd, aluMlt, aluNot, aluAnd, aluOr, aluXor,
                     aluSul, aluSur, aluSsr, aluEq, aluNeq, aluLt, aluLeq};
        immOps   = '{opAddi, opMlti, opAndi, opOri, opXori, opSuli, opSuri, opSsri};
        immFuncs = '{aluAdd, aluMlt, aluAnd, aluOr, aluXor, aluSul, aluSur, aluSsr};
        newProgram(3, 0);
        a = nextRandom();
        b = nextRandom();
        loadConst(1, a);
        loadConst(2, b);
        for (i = 0; i < 14; i++) begin
            emit(rOp(regFuncs[i], 1, 2, 3));
            storeOut(3);
            expected.push_back(expectAlu(regFuncs[i], a, b));
        end
        // Compares again with equal operands
        for (i = 10; i < 14; i++) begin
            emit(rOp(regFuncs[i], 1, 1, 3));
            storeOut(3);
            expected.push_back(expectAlu(regFuncs[i], a, a));
        end
        for (i = 0; i < 8; i++) begin
            imm = immT'(nextRandom() >> 7);
            emit(iOp(immOps[i], 1, 4, imm));
            storeOut(4);
            expected.push_back(expectAlu(immFuncs[i], a, sext(imm)));
        end
        runProgram("alu");
    endtask

    task automatic memoryTest();
        wordT vals [4];
        int   offs [4];
        immT  imm;
        int   i;
        offs = '{0, 8, -4, -64};
        newProgram(3, 0);
        emit(iOp(opAddi, 0, 1, 17'h00100));  // Base address
        for (i = 0; i < 4; i++) begin
            imm = immT'(nextRandom() >> 9);
            vals[i] = sext(imm);
            emit(iOp(opAddi, 0, 2 + i, imm));
            emit(iOp(opSw, 1, 2 + i, immT'(offs[i])));
        end
        emit(iOp(opSw, 0, 2, 17'h00020));
        for (i = 3; i >= 0; i--) begin
            emit(iOp(opLw, 1, 6, immT'(offs[i])));
            storeOut(6);
            expected.push_back(vals[i]);
        end
        emit(iOp(opLw, 0, 7, 17'h00020));
        storeOut(7);
        expected.push_back(vals[0]);
        runProgram("memory");
    endtask

    task automatic branchTest();
        opcodeT bops [8];
        int     bx [8];
        int     by [8];
        wordT   regVal [8];
        int     i;
        bops = '{opBeq, opBeq, opBne, opBne, opBlt, opBlt, opBle, opBle};
        bx   = '{1, 1, 1, 1, 4, 2, 1, 1};
        by   = '{5, 2, 2, 5, 1, 1, 5, 4};
        regVal = '{32'd0, 32'd5, 32'd9, 32'd0, 32'hFFFF_FFFD, 32'd5, 32'd0, 32'd0};
        newProgram(3, 30);  // Ten loop passes of three instructions
        emit(iOp(opAddi, 0, 1, 17'd5));
        emit(iOp(opAddi, 0, 2, 17'd9));
        emit(iOp(opAddi, 0, 4, 17'h1FFFD));
        emit(iOp(opAddi, 0, 5, 17'd5));
        for (i = 0; i < 8; i++) begin
            emit(iOp(opAddi, 0, 3, immT'(i * 2)));
            emit(iOp(bops[i], bx[i], by[i], 17'd1));  // Skips the marker bump
            emit(iOp(opAddi, 3, 3, 17'd1));
            storeOut(3);
            expected.push_back(wordT'(i * 2 + (branchTaken(bops[i], regVal[bx[i]],
                                                          regVal[by[i]]) ? 0 : 1)));
        end
        // Sum of 10 down to 1
        emit(iOp(opAddi, 0, 6, 17'd0));
        emit(iOp(opAddi, 0, 7, 17'd10));
        emit(rOp(aluAdd, 6, 7, 6));
        emit(iOp(opAddi, 7, 7, 17'h1FFFF));
        emit(iOp(opBne, 7, 0, 17'h1FFFD));  // Back to the add
        storeOut(6);
        expected.push_back(32'd55);
        runProgram("branch");
    endtask

    task automatic ledSwitchTest();
        logic [`NIU_LED_BITS-1:0] sw;
        wordT                     r;
        newProgram(3, 0);
        r = nextRandom();
        sw = r[`NIU_LED_BITS-1:0];
        switches = sw;
        emit(iOp(opLw, 0, 1, SwitchImm));
        storeOut(1);
        expected.push_back(wordT'(sw));
        emit(iOp(opAddi, 1, 2, 17'h0FC00));  // Upper bits the LEDs drop
        emit(iOp(opSw, 0, 2, LedImm));
        runProgram("ledSwitch");
        checkValue("ledSwitch ledr", wordT'(sw), wordT'(ledr));
    endtask

    task automatic backPressureTest();
        wordT vals [7];
        immT  imm;
        int   i;
        newProgram(9, 0);
        for (i = 1; i <= 6; i++) begin
            imm = immT'(nextRandom() >> 11);
            vals[i] = sext(imm);
            emit(iOp(opAddi, 0, i, imm));
        end
        // Back-to-back output stores forward and then reversed
        for (i = 1; i <= 6; i++) begin
            storeOut(i);
            expected.push_back(vals[i]);
        end
        for (i = 6; i >= 1; i--) begin
            storeOut(i);
            expected.push_back(vals[i]);
        end
        runProgram("backPressure");
    endtask

    task automatic haltTest();
        newProgram(2, 0);
        emit(iOp(opAddi, 0, 1, 17'd7));
        storeOut(1);
        expected.push_back(32'd7);
        emit({opAlui, 5'd1, 5'd1, 5'd3, 7'd0, 5'b00011});  // op2 00011 is no register function
        storeOut(1);  // Never reached
        runProgram("halt");
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        loadReq  = 1'b0;
        loadWord = '0;
        switches = '0;
        outAck   = 1'b0;
        aluTest();
        memoryTest();
        branchTest();
        ledSwitchTest();
        backPressureTest();
        haltTest();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== hdl/niu32Top.sv ====
`timescale 1ns/1ns
`include "niu32_cfg.svh"

module niu32Top import niu32CorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     loadReq,
    input  loadWordT                 loadWord,
    output logic                     loadAck,
    input  logic [`NIU_LED_BITS-1:0] switches,
    input  logic                     outAck,
    output logic                     outReq,
    output wordT                     outData,
    output logic [`NIU_LED_BITS-1:0] ledr,
    output logic                     halted
);
    ctrlWordT ctrl;
    decodeT   decode;
    wordT     bus;
    wordT     aluResult;
    wordT     imemData;
    wordT     ioAddr;
    imemAddrT imemAddr;
    logic     imemWe;
    logic     coreRun;
    logic     cmpTrue;
    logic     ioStore;
    logic     ioBusy;

    programLoader loader (
        .clk, .reset, .loadReq, .loadWord, .loadAck,
        .imemWe, .imemAddr, .imemData, .coreRun
    );

    controlSequencer sequencer (
        .clk, .reset, .coreRun, .decode, .cmpTrue, .ioBusy, .ctrl, .halted
    );

    datapath dp (
        .clk, .reset, .ctrl, .imemWe, .imemAddr, .imemData, .switches,
        .aluResult, .bus, .decode, .ioStore, .ioAddr
    );

    aluUnit alu (
        .clk, .reset, .bus, .loadA(ctrl.loadA), .loadB(ctrl.loadB),
        .func(ctrl.aluFunc), .result(aluResult), .cmpTrue
    );

    outputPort port (
        .clk, .reset, .ioStore, .ioAddr, .bus, .outAck,
        .outReq, .outData, .ioBusy, .ledr
    );

endmodule

// ==== hdl/outputPort.sv ====
`timescale 1ns/1ns
`include "niu32_cfg.svh"

module outputPort import niu32CorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ioStore,
    input  wordT                     ioAddr,
    input  wordT                     bus,
    input  logic                     outAck,
    output logic                     outReq,
    output wordT                     outData,
    output logic                     ioBusy,
    output logic [`NIU_LED_BITS-1:0] ledr
);
    typedef enum logic [1:0] {sendIdle, sendReq, sendRelease} sendStateT;

    sendStateT state;
    logic      outHit;
    logic      ledHit;

    assign outHit = ioStore && ioAddr == `NIU_ADDR_OUT;
    assign ledHit = ioStore && ioAddr == `NIU_ADDR_LEDR;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sendIdle;
            ledr  <= '0;
        end else begin
            if (ledHit) ledr <= bus[`NIU_LED_BITS-1:0];
            case (state)
                sendIdle:    if (outHit) state <= sendReq;
                sendReq:     if (outAck) state <= sendRelease;
                sendRelease: if (!outAck) state <= sendIdle;  // Host has finished
                default:     state <= sendIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (outHit && state == sendIdle) outData <= bus;
    end

    assign outReq = state == sendReq;
    assign ioBusy = state != sendIdle;

    // Sequencer holds off the next store while a word is in flight
    assert property (@(posedge clk) disable iff (reset) ioStore |-> !ioBusy);

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ns
`include "niu32_cfg.svh"

module datapath import niu32IsaPkg::*, niu32CorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  ctrlWordT                 ctrl,
    input  logic                     imemWe,
    input  imemAddrT                 imemAddr,
    input  wordT                     imemData,
    input  logic [`NIU_LED_BITS-1:0] switches,
    input  wordT                     aluResult,
    output wordT                     bus,
    output decodeT                   decode,
    output logic                     ioStore,
    output wordT                     ioAddr
);
    localparam int DmemBits = $clog2(`NIU_DMEM_WORDS);

    wordT     pc;
    wordT     ir;
    wordT     mar;
    wordT     mdr;
    wordT     immExt;
    wordT     regOut;
    imemAddrT fetchIdx;
    logic     marIo;
    wordT     regFile [2**$bits(regIdxT)];
    wordT     imem [`NIU_IMEM_WORDS];
    wordT     dmem [`NIU_DMEM_WORDS];

    always_comb begin
        decode.op1 = opcodeT'(ir[31:27]);
        decode.rx  = ir[26:22];
        decode.ry  = ir[21:17];
        decode.rz  = ir[16:12];
        decode.imm = ir[16:0];
        decode.op2 = aluFuncT'(ir[4:0]);
    end

    assign immExt   = {{(`NIU_WORD_BITS - $bits(immT)){decode.imm[16]}}, decode.imm};
    assign regOut   = (ctrl.regSel == '0) ? '0 : regFile[ctrl.regSel];  // r0 reads zero
    assign fetchIdx = pc[$bits(imemAddrT)+1:2];

    always_comb begin
        case (ctrl.busSrc)
            busPc:    bus = pc;
            busReg:   bus = regOut;
            busMem:   bus = mdr;
            busImm:   bus = immExt;
            busShImm: bus = immExt << 2;  // Branch offset in words
            busAlu:   bus = aluResult;
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `NIU_PC_START;
        end else if (ctrl.loadPc) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (imemWe) imem[imemAddr] <= imemData;
        if (ctrl.loadIr) ir <= imem[fetchIdx];
        if (ctrl.writeReg) regFile[ctrl.regSel] <= bus;
        if (ctrl.loadMar) begin
            mar <= bus;
            // Read straight from the new address
            if (bus == `NIU_ADDR_SWITCH) begin
                mdr <= {{(`NIU_WORD_BITS - `NIU_LED_BITS){1'b0}}, switches};
            end else begin
                mdr <= dmem[bus[DmemBits+1:2]];
            end
        end
        if (ctrl.writeMem && !marIo) dmem[mar[DmemBits+1:2]] <= bus;
    end

    assign marIo   = mar[`NIU_WORD_BITS-1:16] == `NIU_IO_PREFIX;
    assign ioStore = ctrl.ioStore && marIo;  // Output port decodes the rest
    assign ioAddr  = mar;

endmodule

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/1ns

module controlSequencer import niu32IsaPkg::*, niu32CorePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     coreRun,
    input  decodeT   decode,
    input  logic     cmpTrue,
    input  logic     ioBusy,
    output ctrlWordT ctrl,
    output logic     halted
);
    seqStateT state;
    seqStateT nextState;
    logic     isAlui;
    aluFuncT  execFunc;

    // Register functions the core implements
    function automatic logic op2Legal(aluFuncT f);
        case (f)
            aluSub, aluAdd, aluMlt, aluNot, aluAnd, aluOr, aluXor,
            aluSul, aluSur, aluSsr, aluEq, aluNeq, aluLt, aluLeq: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic aluFuncT branchFunc(opcodeT op);
        case (op)
            opBne:   return aluNeq;
            opBlt:   return aluLt;
            opBle:   return aluLeq;
            default: return aluEq;
        endcase
    endfunction

    assign isAlui   = decode.op1 == opAlui;
    // Immediate opcodes share the secondary encodings
    assign execFunc = isAlui ? decode.op2 : aluFuncT'(decode.op1);
    assign halted   = state == sHalt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl         = '0;
        ctrl.aluFunc = aluAdd;  // Address and branch target sums
        ctrl.busSrc  = busNone;
        nextState    = state;
        case (state)
            sFetch: begin
                if (ioBusy) begin
                    nextState = sIoWait;
                end else if (coreRun) begin
                    ctrl.loadIr = 1'b1;
                    ctrl.incPc  = 1'b1;
                    nextState   = sDecode;
                end
            end
            sDecode: begin
                // A takes rx for every kept instruction
                ctrl.regSel = decode.rx;
                ctrl.busSrc = busReg;
                ctrl.loadA  = 1'b1;
                case (decode.op1)
                    opAlui: nextState = op2Legal(decode.op2) ? sOpB : sHalt;
                    opAddi, opMlti, opAndi, opOri, opXori,
                    opSuli, opSuri, opSsri: nextState = sOpB;
                    opLw, opSw: nextState = sAddrB;
                    opBeq, opBne, opBlt, opBle: nextState = sBrB;
                    default: nextState = sHalt;
                endcase
            end
            sOpB: begin
                ctrl.regSel = decode.ry;
                ctrl.busSrc = isAlui ? busReg : busImm;
                ctrl.loadB  = 1'b1;
                nextState   = sExec;
            end
            sExec: begin
                ctrl.aluFunc = execFunc;
                nextState    = sWriteBack;
            end
            sWriteBack: begin
                ctrl.regSel   = isAlui ? decode.rz : decode.ry;
                ctrl.busSrc   = busAlu;
                ctrl.writeReg = 1'b1;
                nextState     = sFetch;
            end
            sAddrB: begin
                ctrl.busSrc = busImm;
                ctrl.loadB  = 1'b1;
                nextState   = sAddrCalc;
            end
            sAddrCalc: nextState = sAddrLoad;
            sAddrLoad: begin
                ctrl.busSrc  = busAlu;
                ctrl.loadMar = 1'b1;  // MDR reads in the same edge
                nextState    = (decode.op1 == opLw) ? sLoadWb : sStore;
            end
            sLoadWb: begin
                ctrl.regSel   = decode.ry;
                ctrl.busSrc   = busMem;
                ctrl.writeReg = 1'b1;
                nextState     = sFetch;
            end
            sStore: begin
                ctrl.regSel   = decode.ry;
                ctrl.busSrc   = busReg;
                ctrl.writeMem = 1'b1;
                ctrl.ioStore  = 1'b1;  // Datapath picks memory or I/O
                nextState     = sFetch;
            end
            sBrB: begin
                ctrl.regSel = decode.ry;
                ctrl.busSrc = busReg;
                ctrl.loadB  = 1'b1;
                nextState   = sBrCmp;
            end
            sBrCmp: begin
                ctrl.aluFunc = branchFunc(decode.op1);
                nextState    = sBrTest;
            end
            sBrTest: begin
                // PC already points past the branch
                ctrl.busSrc = busPc;
                ctrl.loadA  = 1'b1;
                nextState   = cmpTrue ? sBrOff : sFetch;
            end
            sBrOff: begin
                ctrl.busSrc = busShImm;
                ctrl.loadB  = 1'b1;
                nextState   = sBrAdd;
            end
            sBrAdd: nextState = sBrJump;
            sBrJump: begin
                ctrl.busSrc = busAlu;
                ctrl.loadPc = 1'b1;
                nextState   = sFetch;
            end
            sIoWait: if (!ioBusy) nextState = sFetch;
            sHalt: nextState = sHalt;  // Until reset
            default: nextState = sFetch;
        endcase
    end

    // Back-pressure only ever follows a store this sequencer issued
    assert property (@(posedge clk) disable iff (reset) $rose(ioBusy) |-> $past(state) == sStore);

endmodule

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit import niu32IsaPkg::*, niu32CorePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  wordT    bus,
    input  logic    loadA,
    input  logic    loadB,
    input  aluFuncT func,
    output wordT    result,
    output logic    cmpTrue
);
    wordT       a;
    wordT       b;
    wordT       nextResult;
    logic [4:0] shamt;

    assign shamt = b[4:0];  // Low five bits only

    always_ff @(posedge clk) begin
        if (loadA) a <= bus;
        if (loadB) b <= bus;
    end

    always_comb begin
        case (func)
            aluSub:  nextResult = a - b;
            aluAdd:  nextResult = a + b;
            aluMlt:  nextResult = a * b;
            aluNot:  nextResult = ~a;
            aluAnd:  nextResult = a & b;
            aluOr:   nextResult = a | b;
            aluXor:  nextResult = a ^ b;
            aluSul:  nextResult = a << shamt;
            aluSur:  nextResult = a >> shamt;
            aluSsr:  nextResult = $signed(a) >>> shamt;
            // Compares are signed
            aluEq:   nextResult = wordT'(a == b);
            aluNeq:  nextResult = wordT'(a != b);
            aluLt:   nextResult = wordT'($signed(a) < $signed(b));
            aluLeq:  nextResult = wordT'($signed(a) <= $signed(b));
            default: nextResult = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= nextResult;
        end
    end

    assign cmpTrue = result[0];

endmodule

// ==== hdl/programLoader.sv ====
`timescale 1ns/1ns

module programLoader import niu32CorePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     loadReq,
    input  loadWordT loadWord,
    output logic     loadAck,
    output logic     imemWe,
    output imemAddrT imemAddr,
    output wordT     imemData,
    output logic     coreRun
);
    typedef enum logic [1:0] {loadIdle, loadWrite, loadHold} loadStateT;

    loadStateT state;
    loadWordT  held;  // Packet captured at request

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= loadIdle;
            coreRun <= 1'b0;
        end else begin
            case (state)
                loadIdle: if (loadReq && !coreRun) state <= loadWrite;
                loadWrite: state <= loadHold;
                loadHold: begin
                    // Four-phase return to zero
                    if (!loadReq) begin
                        state <= loadIdle;
                        if (held.last) coreRun <= 1'b1;
                    end
                end
                default: state <= loadIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == loadIdle && loadReq) held <= loadWord;
    end

    assign imemWe   = state == loadWrite;
    assign imemAddr = held.addr;
    assign imemData = held.data;
    assign loadAck  = state == loadHold;

    // Host keeps the request up until the word has been taken
    assert property (@(posedge clk) disable iff (reset) $fell(loadReq) |-> loadAck);

endmodule

// ==== hdl/niu32CorePkg.sv ====
`include "niu32_cfg.svh"

package niu32CorePkg;
    import niu32IsaPkg::*;

    typedef logic [`NIU_WORD_BITS-1:0] wordT;
    typedef logic [$clog2(`NIU_IMEM_WORDS)-1:0] imemAddrT;

    typedef enum logic [4:0] {
        sFetch, sDecode,
        sOpB, sExec, sWriteBack,          // ALU, register or immediate
        sAddrB, sAddrCalc, sAddrLoad,     // Shared by LW and SW
        sLoadWb, sStore,
        sBrB, sBrCmp, sBrTest, sBrOff, sBrAdd, sBrJump,
        sIoWait, sHalt
    } seqStateT;

    typedef enum logic [2:0] {
        busNone, busPc, busReg, busMem, busImm, busShImm, busAlu
    } busSrcT;

    typedef struct packed {
        logic    loadPc;
        logic    incPc;
        logic    loadIr;
        logic    loadMar;
        logic    writeMem;
        logic    writeReg;
        regIdxT  regSel;
        logic    loadA;
        logic    loadB;
        aluFuncT aluFunc;
        busSrcT  busSrc;
        logic    ioStore;
    } ctrlWordT;

    typedef struct packed {
        opcodeT  op1;
        aluFuncT op2;
        regIdxT  rx;
        regIdxT  ry;
        regIdxT  rz;
        immT     imm;
    } decodeT;

    typedef struct packed {
        imemAddrT addr;
        wordT     data;
        logic     last;
    } loadWordT;

endpackage

// ==== hdl/niu32IsaPkg.sv ====
package niu32IsaPkg;

    typedef logic [4:0]  regIdxT;
    typedef logic [16:0] immT;

    // Primary opcode in IR[31:27]
    typedef enum logic [4:0] {
        opAlui = 5'b00000,
        opAddi = 5'b00001,
        opMlti = 5'b00010,
        opAndi = 5'b00101,
        opOri  = 5'b00110,
        opXori = 5'b00111,
        opSuli = 5'b01000,
        opSuri = 5'b01010,
        opSsri = 5'b01011,
        opLw   = 5'b10000,
        opSw   = 5'b10011,
        opBeq  = 5'b11000,
        opBne  = 5'b11001,
        opBlt  = 5'b11010,
        opBle  = 5'b11011
    } opcodeT;

    // Secondary opcode encodings also used by the immediate forms
    typedef enum logic [4:0] {
        aluSub = 5'b00000,
        aluAdd = 5'b00001,
        aluMlt = 5'b00010,
        aluNot = 5'b00100,
        aluAnd = 5'b00101,
        aluOr  = 5'b00110,
        aluXor = 5'b00111,
        aluSul = 5'b01000,
        aluSur = 5'b01010,
        aluSsr = 5'b01011,
        aluEq  = 5'b10000,
        aluNeq = 5'b10001,
        aluLt  = 5'b10010,
        aluLeq = 5'b10011
    } aluFuncT;

endpackage

// ==== hdl/niu32_cfg.svh ====
`ifndef NIU32_CFG_SVH
`define NIU32_CFG_SVH

// Datapath width
`define NIU_WORD_BITS 32

// Memory depths in words
`define NIU_IMEM_WORDS 256
`define NIU_DMEM_WORDS 256

`define NIU_PC_START 32'h0000_0000

// Memory-mapped I/O
`define NIU_ADDR_LEDR   32'hFFFF_0020
`define NIU_ADDR_OUT    32'hFFFF_0000
`define NIU_ADDR_SWITCH 32'hFFFF_0120
`define NIU_IO_PREFIX   16'hFFFF  // Upper half of every I/O address

`define NIU_LED_BITS 10  // Red LEDs and switches alike

`endif
